// ==== hw/ita_cfg_pkg.sv ====
// shared widths and vector types of the tile controller
// counters and dimensions are unsigned, 16 bits wide

package ita_cfg_pkg;

  // beat and tile counters
  localparam int unsigned counter_w = 16;

  localparam int unsigned tile_cnt_w = 8;  // tiles along one matrix side
  localparam int unsigned dim_w = 16;  // matrix dimension in elements
  localparam int unsigned bias_w = 24;  // one bias lane

  // beat index inside a tile, tile position
  typedef logic [counter_w-1:0] counter_t;

  // tile counts as given by the host
  typedef logic [tile_cnt_w-1:0] tile_cnt_t;

  // outer matrix dimension
  typedef logic [dim_w-1:0] dim_t;

  // single bias element, one per lane
  typedef logic [bias_w-1:0] bias_elem_t;

endpackage

// ==== hw/ita_step_pkg.sv ====
// layer and step encodings of the tile controller
// attention layers are not supported

package ita_step_pkg;

  // layer requested by the host
  typedef enum logic [1:0] {
    Linear,
    Feedforward
  } layer_e;

  // sequencer step, Idle between layers
  typedef enum logic [1:0] {
    Idle,
    MatMul,
    F1,
    F2
  } step_e;

endpackage

// ==== hw/ita_beat_gate.sv ====
// three-way join of input, weight and bias streams with output-tile credit
// tile_dim*tile_dim/num_lanes beats per tile; fifo_depth must be at least 1

module ita_beat_gate #(
  parameter int unsigned num_lanes  = 16,
  parameter int unsigned tile_dim   = 64,
  parameter int unsigned fifo_depth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  inp_valid_i,
  input  logic                  weight_valid_i,
  input  logic                  bias_valid_i,
  input  logic                  oup_valid_i,
  input  logic                  oup_ready_i,
  input  logic                  active_i,
  input  logic                  last_inner_i,
  output logic                  inp_ready_o,
  output logic                  weight_ready_o,
  output logic                  bias_ready_o,
  output logic                  calc_en_o,
  output ita_cfg_pkg::counter_t beat_idx_o,
  output logic                  tile_done_o
);

  localparam int unsigned beats_per_tile = tile_dim * tile_dim / num_lanes;
  localparam int unsigned credit_w = $clog2(fifo_depth + 1);

  ita_cfg_pkg::counter_t count_q;
  logic [credit_w-1:0]   ongoing_q;  // output tiles in flight
  logic                  open;
  logic                  accept;
  logic                  last_beat;
  logic                  push;
  logic                  pop;

  // stall once the output FIFO is full
  assign open = active_i && (ongoing_q < credit_w'(fifo_depth));

  assign inp_ready_o    = open && weight_valid_i;
  assign weight_ready_o = open && inp_valid_i;
  assign bias_ready_o   = open && weight_valid_i;

  assign accept    = open && inp_valid_i && weight_valid_i && bias_valid_i;
  assign last_beat = (count_q == ita_cfg_pkg::counter_t'(beats_per_tile - 1));

  assign calc_en_o   = accept;
  assign beat_idx_o  = count_q;
  assign tile_done_o = accept && last_beat;

  // a finished output tile takes one credit
  assign push = tile_done_o && last_inner_i;
  assign pop  = oup_valid_i && oup_ready_i && ((ongoing_q != '0) || push);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (accept) begin
      count_q <= last_beat ? '0 : count_q + 1'b1;  // wrap at tile end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ongoing_q <= '0;
    end else if (push && !pop) begin
      ongoing_q <= ongoing_q + 1'b1;
    end else if (pop && !push) begin
      ongoing_q <= ongoing_q - 1'b1;
    end
  end

endmodule

// ==== hw/ita_tile_sequencer.sv ====
// step FSM with inner and outer tile counters for Linear and Feedforward
// tile counts must be nonzero; control inputs held while busy

module ita_tile_sequencer #(
  parameter int unsigned num_lanes = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  ita_step_pkg::layer_e   layer_i,
  input  ita_cfg_pkg::tile_cnt_t tile_s_i,
  input  ita_cfg_pkg::tile_cnt_t tile_e_i,
  input  ita_cfg_pkg::tile_cnt_t tile_f_i,
  input  ita_cfg_pkg::tile_cnt_t tile_p_i,
  input  ita_cfg_pkg::dim_t      seq_length_i,
  input  ita_cfg_pkg::dim_t      embed_size_i,
  input  ita_cfg_pkg::dim_t      ff_size_i,
  input  logic                   tile_done_i,
  output ita_step_pkg::step_e    step_o,
  output logic                   active_o,
  output logic                   busy_o,
  output ita_cfg_pkg::counter_t  tile_x_o,
  output ita_cfg_pkg::counter_t  tile_y_o,
  output ita_cfg_pkg::counter_t  inner_tile_o,
  output logic                   first_inner_tile_o,
  output logic                   last_inner_tile_o,
  output logic                   pad_en_o,
  output ita_cfg_pkg::dim_t      rows_o,
  output ita_cfg_pkg::dim_t      cols_o
);

  // lanes are addressed by bit slicing downstream
  if ((num_lanes == 0) || ((num_lanes & (num_lanes - 1)) != 0)) begin : g_lane_check
    $error("num_lanes must be a power of two");
  end

  ita_step_pkg::step_e   step_q;
  ita_step_pkg::step_e   next_step;
  ita_cfg_pkg::counter_t inner_q, tile_x_q, tile_y_q;
  ita_cfg_pkg::counter_t k_cnt;  // inner tiles per output tile
  ita_cfg_pkg::counter_t x_cnt;  // output tiles along x
  ita_cfg_pkg::counter_t y_cnt;
  logic                  last_x, last_y;

  // per-step extents and bounds
  always_comb begin
    k_cnt     = ita_cfg_pkg::counter_t'(tile_e_i);
    x_cnt     = ita_cfg_pkg::counter_t'(tile_p_i);
    rows_o    = seq_length_i;
    cols_o    = embed_size_i;
    pad_en_o  = 1'b0;
    next_step = ita_step_pkg::Idle;
    case (step_q)
      ita_step_pkg::F1: begin
        x_cnt     = ita_cfg_pkg::counter_t'(tile_f_i);
        cols_o    = ff_size_i;
        pad_en_o  = 1'b1;
        next_step = ita_step_pkg::F2;
      end
      ita_step_pkg::F2: begin
        k_cnt    = ita_cfg_pkg::counter_t'(tile_f_i);
        x_cnt    = ita_cfg_pkg::counter_t'(tile_e_i);
        pad_en_o = 1'b1;  // cols stay at embed_size
      end
      default: ;  // MatMul keeps the defaults, no padding
    endcase
  end

  assign y_cnt  = ita_cfg_pkg::counter_t'(tile_s_i);
  assign last_x = (tile_x_q == x_cnt - 1'b1);
  assign last_y = (tile_y_q == y_cnt - 1'b1);

  assign active_o           = (step_q != ita_step_pkg::Idle);
  assign busy_o             = active_o;  // high from start until back in Idle
  assign step_o             = step_q;
  assign tile_x_o           = tile_x_q;
  assign tile_y_o           = tile_y_q;
  assign inner_tile_o       = inner_q;
  assign first_inner_tile_o = (inner_q == '0);
  assign last_inner_tile_o  = active_o && (inner_q == k_cnt - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= ita_step_pkg::Idle;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
    end else if (step_q == ita_step_pkg::Idle) begin
      if (start_i) begin
        step_q <= (layer_i == ita_step_pkg::Feedforward) ? ita_step_pkg::F1
                                                          : ita_step_pkg::MatMul;
      end
    end else if (tile_done_i) begin
      if (!last_inner_tile_o) begin
        inner_q <= inner_q + 1'b1;
      end else begin
        inner_q <= '0;
        if (!last_x) begin
          tile_x_q <= tile_x_q + 1'b1;
        end else begin
          tile_x_q <= '0;
          if (!last_y) begin
            tile_y_q <= tile_y_q + 1'b1;
          end else begin
            tile_y_q <= '0;
            step_q   <= next_step;  // all outer tiles of this step done
          end
        end
      end
    end
  end

endmodule

// ==== hw/ita_edge_padder.sv ====
// zeroes bias lanes and requant bits that fall outside the matrix bounds
// tile_dim a power of two; result registered on the accepted beat

module ita_edge_padder #(
  parameter int unsigned num_lanes = 16,
  parameter int unsigned tile_dim  = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  calc_en_i,
  input  ita_cfg_pkg::counter_t                 beat_idx_i,
  input  ita_cfg_pkg::counter_t                 tile_x_i,
  input  ita_cfg_pkg::counter_t                 tile_y_i,
  input  logic                                  pad_en_i,
  input  ita_cfg_pkg::dim_t                     rows_i,
  input  ita_cfg_pkg::dim_t                     cols_i,
  input  ita_cfg_pkg::bias_elem_t [num_lanes-1:0] inp_bias_i,
  input  logic                                  requant_add_i,
  output ita_cfg_pkg::bias_elem_t [num_lanes-1:0] inp_bias_pad_o,
  output logic [num_lanes-1:0]                  requant_add_o
);

  localparam int unsigned row_bits = $clog2(tile_dim);

  ita_cfg_pkg::counter_t row;
  ita_cfg_pkg::counter_t col_base;  // column of lane 0
  logic [num_lanes-1:0]  keep;

  // beats run down the rows first, then step one lane group right
  always_comb begin
    row      = (beat_idx_i & ita_cfg_pkg::counter_t'(tile_dim - 1))
             + tile_y_i * ita_cfg_pkg::counter_t'(tile_dim);
    col_base = (beat_idx_i >> row_bits) * ita_cfg_pkg::counter_t'(num_lanes)
             + tile_x_i * ita_cfg_pkg::counter_t'(tile_dim);
    for (int lane = 0; lane < num_lanes; lane++) begin
      keep[lane] = !pad_en_i
                || ((row < rows_i)
                    && ((col_base + ita_cfg_pkg::counter_t'(lane)) < cols_i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inp_bias_pad_o <= '0;
      requant_add_o  <= '0;
    end else if (calc_en_i) begin
      for (int lane = 0; lane < num_lanes; lane++) begin
        inp_bias_pad_o[lane] <= keep[lane] ? inp_bias_i[lane] : '0;
        requant_add_o[lane]  <= keep[lane] && requant_add_i;  // one bit per lane
      end
    end
  end

endmodule

// ==== hw/ita_controller.sv ====
// tile controller top; control inputs must stay stable while busy_o is high
// only Linear and Feedforward layers

module ita_controller #(
  parameter int unsigned num_lanes  = 16,
  parameter int unsigned tile_dim   = 64,
  parameter int unsigned fifo_depth = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  start_i,
  input  ita_step_pkg::layer_e                  layer_i,
  input  ita_cfg_pkg::tile_cnt_t                tile_s_i,
  input  ita_cfg_pkg::tile_cnt_t                tile_e_i,
  input  ita_cfg_pkg::tile_cnt_t                tile_f_i,
  input  ita_cfg_pkg::tile_cnt_t                tile_p_i,
  input  ita_cfg_pkg::dim_t                     seq_length_i,
  input  ita_cfg_pkg::dim_t                     embed_size_i,
  input  ita_cfg_pkg::dim_t                     ff_size_i,
  input  logic                                  inp_valid_i,
  output logic                                  inp_ready_o,
  input  logic                                  weight_valid_i,
  output logic                                  weight_ready_o,
  input  logic                                  bias_valid_i,
  output logic                                  bias_ready_o,
  input  logic                                  oup_valid_i,
  input  logic                                  oup_ready_i,
  input  ita_cfg_pkg::bias_elem_t [num_lanes-1:0] inp_bias_i,
  input  logic                                  requant_add_i,
  output ita_cfg_pkg::bias_elem_t [num_lanes-1:0] inp_bias_pad_o,
  output logic [num_lanes-1:0]                  requant_add_o,
  output logic                                  calc_en_o,
  output ita_step_pkg::step_e                   step_o,
  output logic                                  busy_o,
  output ita_cfg_pkg::counter_t                 tile_x_o,
  output ita_cfg_pkg::counter_t                 tile_y_o,
  output ita_cfg_pkg::counter_t                 inner_tile_o,
  output logic                                  first_inner_tile_o,
  output logic                                  last_inner_tile_o
);

  ita_cfg_pkg::counter_t beat_idx;
  logic                  tile_done;
  logic                  active;
  logic                  pad_en;
  ita_cfg_pkg::dim_t     rows, cols;

  ita_beat_gate #(
    .num_lanes (num_lanes),
    .tile_dim  (tile_dim),
    .fifo_depth(fifo_depth)
  ) u_gate (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .inp_valid_i   (inp_valid_i),
    .weight_valid_i(weight_valid_i),
    .bias_valid_i  (bias_valid_i),
    .oup_valid_i   (oup_valid_i),
    .oup_ready_i   (oup_ready_i),
    .active_i      (active),
    .last_inner_i  (last_inner_tile_o),
    .inp_ready_o   (inp_ready_o),
    .weight_ready_o(weight_ready_o),
    .bias_ready_o  (bias_ready_o),
    .calc_en_o     (calc_en_o),
    .beat_idx_o    (beat_idx),
    .tile_done_o   (tile_done)
  );

  ita_tile_sequencer #(
    .num_lanes(num_lanes)
  ) u_seq (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (start_i),
    .layer_i           (layer_i),
    .tile_s_i          (tile_s_i),
    .tile_e_i          (tile_e_i),
    .tile_f_i          (tile_f_i),
    .tile_p_i          (tile_p_i),
    .seq_length_i      (seq_length_i),
    .embed_size_i      (embed_size_i),
    .ff_size_i         (ff_size_i),
    .tile_done_i       (tile_done),
    .step_o            (step_o),
    .active_o          (active),
    .busy_o            (busy_o),
    .tile_x_o          (tile_x_o),
    .tile_y_o          (tile_y_o),
    .inner_tile_o      (inner_tile_o),
    .first_inner_tile_o(first_inner_tile_o),
    .last_inner_tile_o (last_inner_tile_o),
    .pad_en_o          (pad_en),
    .rows_o            (rows),
    .cols_o            (cols)
  );

  // padding sees the beat and tile position of the current acceptance
  ita_edge_padder #(
    .num_lanes(num_lanes),
    .tile_dim (tile_dim)
  ) u_pad (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .calc_en_i     (calc_en_o),
    .beat_idx_i    (beat_idx),
    .tile_x_i      (tile_x_o),
    .tile_y_i      (tile_y_o),
    .pad_en_i      (pad_en),
    .rows_i        (rows),
    .cols_i        (cols),
    .inp_bias_i    (inp_bias_i),
    .requant_add_i (requant_add_i),
    .inp_bias_pad_o(inp_bias_pad_o),
    .requant_add_o (requant_add_o)
  );

endmodule

// ==== verification/ita_controller_sva.sv ====
// handshake and reset checks, bound into every ita_controller instance
// join and credit limit are checked by the testbench model

module ita_controller_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic inp_valid_i,
  input logic weight_valid_i,
  input logic bias_valid_i,
  input logic inp_ready_o,
  input logic weight_ready_o,
  input logic bias_ready_o,
  input logic calc_en_o,
  input logic busy_o
);

  // a beat needs all three streams
  a_calc_en_join: assert property (@(posedge clk_i) disable iff (!rst_ni)
    calc_en_o |-> (inp_valid_i && weight_valid_i && bias_valid_i))
    else $error("calc_en_o high without all three valids");

  a_inp_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inp_ready_o |-> weight_valid_i)
    else $error("inp_ready_o high without weight_valid_i");

  a_weight_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    weight_ready_o |-> inp_valid_i)
    else $error("weight_ready_o high without inp_valid_i");

  a_bias_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bias_ready_o |-> weight_valid_i)
    else $error("bias_ready_o high without weight_valid_i");

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !(inp_ready_o || weight_ready_o || bias_ready_o || calc_en_o || busy_o))
    else $error("outputs active during reset");

endmodule

bind ita_controller ita_controller_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .inp_valid_i   (inp_valid_i),
  .weight_valid_i(weight_valid_i),
  .bias_valid_i  (bias_valid_i),
  .inp_ready_o   (inp_ready_o),
  .weight_ready_o(weight_ready_o),
  .bias_ready_o  (bias_ready_o),
  .calc_en_o     (calc_en_o),
  .busy_o        (busy_o)
);

// ==== verification/ita_controller_tb.sv ====
// testbench for the tile controller with 4 lanes, 4x4 tiles and 2 tiles of credit
// a reference model tracks steps, tile positions, credit and padding per beat

module ita_controller_tb;

  localparam int unsigned num_lanes  = 4;
  localparam int unsigned tile_dim   = 4;
  localparam int unsigned fifo_depth = 2;
  localparam int unsigned beats      = tile_dim * tile_dim / num_lanes;
  localparam int          timeout_cycles = 4000;
  localparam int          num_cases  = 4;

  // one row of the stimulus table
  typedef struct packed {
    ita_step_pkg::layer_e   layer;
    ita_cfg_pkg::tile_cnt_t tile_s;
    ita_cfg_pkg::tile_cnt_t tile_e;
    ita_cfg_pkg::tile_cnt_t tile_f;
    ita_cfg_pkg::tile_cnt_t tile_p;
    ita_cfg_pkg::dim_t      seq_length;
    ita_cfg_pkg::dim_t      embed_size;
    ita_cfg_pkg::dim_t      ff_size;
    logic                   stall;  // hold outputs back until credit runs out
  } case_t;

  logic                                    clk_i;
  logic                                    rst_ni;
  logic                                    start_i;
  ita_step_pkg::layer_e                    layer_i;
  ita_cfg_pkg::tile_cnt_t                  tile_s_i, tile_e_i, tile_f_i, tile_p_i;
  ita_cfg_pkg::dim_t                       seq_length_i, embed_size_i, ff_size_i;
  logic                                    inp_valid_i, weight_valid_i, bias_valid_i;
  logic                                    inp_ready_o, weight_ready_o, bias_ready_o;
  logic                                    oup_valid_i, oup_ready_i;
  ita_cfg_pkg::bias_elem_t [num_lanes-1:0] inp_bias_i;
  logic                                    requant_add_i;
  ita_cfg_pkg::bias_elem_t [num_lanes-1:0] inp_bias_pad_o;
  logic [num_lanes-1:0]                    requant_add_o;
  logic                                    calc_en_o;
  ita_step_pkg::step_e                     step_o;
  logic                                    busy_o;
  ita_cfg_pkg::counter_t                   tile_x_o, tile_y_o, inner_tile_o;
  logic                                    first_inner_tile_o, last_inner_tile_o;

  // reference model state
  case_t                                   cases[num_cases];
  ita_step_pkg::step_e                     step_m;
  int                                      n_m;  // beats accepted in this step
  int                                      credit_m;
  ita_cfg_pkg::bias_elem_t [num_lanes-1:0] exp_bias;
  logic [num_lanes-1:0]                    exp_req;
  int                                      dut_count[4];
  int                                      stall_cycles;
  bit                                      released;
  int                                      errors;
  int                                      checks;
  int                                      tests;

  ita_controller #(
    .num_lanes (num_lanes),
    .tile_dim  (tile_dim),
    .fifo_depth(fifo_depth)
  ) u_dut (
    .clk_i, .rst_ni, .start_i, .layer_i, .tile_s_i, .tile_e_i, .tile_f_i, .tile_p_i,
    .seq_length_i, .embed_size_i, .ff_size_i, .inp_valid_i, .inp_ready_o,
    .weight_valid_i, .weight_ready_o, .bias_valid_i, .bias_ready_o, .oup_valid_i,
    .oup_ready_i, .inp_bias_i, .requant_add_i, .inp_bias_pad_o, .requant_add_o,
    .calc_en_o, .step_o, .busy_o, .tile_x_o, .tile_y_o, .inner_tile_o,
    .first_inner_tile_o, .last_inner_tile_o
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // inner count, x extent and bounds of a step
  task automatic step_geometry(input ita_step_pkg::step_e s, input case_t c,
                               output int k, output int x, output int rows,
                               output int cols, output bit pad);
    k    = 1;
    x    = 1;
    rows = int'(c.seq_length);
    cols = int'(c.embed_size);
    pad  = 1'b0;
    case (s)
      ita_step_pkg::MatMul: begin
        k = int'(c.tile_e);
        x = int'(c.tile_p);
      end
      ita_step_pkg::F1: begin
        k    = int'(c.tile_e);
        x    = int'(c.tile_f);
        cols = int'(c.ff_size);
        pad  = 1'b1;
      end
      ita_step_pkg::F2: begin
        k   = int'(c.tile_f);
        x   = int'(c.tile_e);
        pad = 1'b1;
      end
      default: ;
    endcase
  endtask

  function automatic ita_step_pkg::step_e step_after(input ita_step_pkg::step_e s);
    return (s == ita_step_pkg::F1) ? ita_step_pkg::F2 : ita_step_pkg::Idle;
  endfunction

  task automatic drive_inputs(input bit hold_out, input bit quiet);
    ita_cfg_pkg::bias_elem_t [num_lanes-1:0] bias_v;
    int                                      lane;
    for (lane = 0; lane < num_lanes; lane++) begin
      bias_v[lane] = ita_cfg_pkg::bias_elem_t'($urandom);
    end
    inp_valid_i    <= !quiet && (hold_out || (($urandom % 4) != 0));
    weight_valid_i <= !quiet && (hold_out || (($urandom % 4) != 0));
    bias_valid_i   <= !quiet && (hold_out || (($urandom % 4) != 0));
    oup_valid_i    <= quiet || (!hold_out && (($urandom % 2) != 0));
    oup_ready_i    <= quiet || (($urandom % 2) != 0);  // quiet cycles drain the credit
    inp_bias_i     <= bias_v;
    requant_add_i  <= ($urandom % 2) != 0;
  endtask

  // compare one cycle at the falling edge, then advance the model
  task automatic check_cycle(input case_t c);
    int k, x, rows, cols, tile, inner, outer, tx, ty, beat, row, col, lane;
    bit pad, join_ok, acc, push, pop, keep;
    step_geometry(step_m, c, k, x, rows, cols, pad);
    beat    = n_m % beats;
    tile    = n_m / beats;
    inner   = tile % k;
    outer   = tile / k;
    tx      = outer % x;
    ty      = outer / x;
    push    = 1'b0;
    join_ok = (step_m != ita_step_pkg::Idle) && (credit_m < fifo_depth);
    acc     = join_ok && inp_valid_i && weight_valid_i && bias_valid_i;
    check_value("inp_ready_o", inp_ready_o, join_ok && weight_valid_i);
    check_value("weight_ready_o", weight_ready_o, join_ok && inp_valid_i);
    check_value("bias_ready_o", bias_ready_o, join_ok && weight_valid_i);
    check_value("calc_en_o", calc_en_o, acc);
    check_value("step_o", step_o, step_m);
    check_value("busy_o", busy_o, step_m != ita_step_pkg::Idle);
    check_value("inp_bias_pad_o", inp_bias_pad_o, exp_bias);
    check_value("requant_add_o", requant_add_o, exp_req);
    if (step_m != ita_step_pkg::Idle) begin
      check_value("tile_x_o", tile_x_o, tx);
      check_value("tile_y_o", tile_y_o, ty);
      check_value("inner_tile_o", inner_tile_o, inner);
      check_value("first_inner_tile_o", first_inner_tile_o, inner == 0);
      check_value("last_inner_tile_o", last_inner_tile_o, inner == k - 1);
    end
    if (acc) begin
      row = beat % tile_dim + ty * tile_dim;
      for (lane = 0; lane < num_lanes; lane++) begin
        col  = (beat / tile_dim) * num_lanes + tx * tile_dim + lane;
        keep = !pad || ((row < rows) && (col < cols));
        exp_bias[lane] = keep ? inp_bias_i[lane] : '0;
        exp_req[lane]  = keep && requant_add_i;
      end
      push = (beat == beats - 1) && (inner == k - 1);  // output tile closes
      n_m++;
      if (n_m == int'(c.tile_s) * x * k * beats) begin
        step_m = step_after(step_m);
        n_m    = 0;
      end
    end
    pop = oup_valid_i && oup_ready_i;
    if (push && !pop) begin
      credit_m++;
    end else if (pop && !push && (credit_m > 0)) begin
      credit_m--;
    end
  endtask

  task automatic run_case(input int idx);
    case_t c;
    int    cycles;
    int    errors_before;
    int    s;
    c             = cases[idx];
    errors_before = errors;
    n_m           = 0;
    stall_cycles  = 0;
    released      = !c.stall;
    cycles        = 0;
    for (s = 0; s < 4; s++) begin
      dut_count[s] = 0;
    end
    @(posedge clk_i);
    layer_i      <= c.layer;
    tile_s_i     <= c.tile_s;
    tile_e_i     <= c.tile_e;
    tile_f_i     <= c.tile_f;
    tile_p_i     <= c.tile_p;
    seq_length_i <= c.seq_length;
    embed_size_i <= c.embed_size;
    ff_size_i    <= c.ff_size;
    start_i      <= 1'b1;
    drive_inputs(1'b0, 1'b1);
    @(negedge clk_i);
    check_cycle(c);  // start is taken on the next edge
    @(posedge clk_i);
    start_i <= 1'b0;
    step_m  = (c.layer == ita_step_pkg::Feedforward) ? ita_step_pkg::F1
                                                     : ita_step_pkg::MatMul;
    @(negedge clk_i);
    check_cycle(c);  // busy one cycle after start, no valids yet
    while ((step_m != ita_step_pkg::Idle) && (cycles < timeout_cycles)) begin
      @(posedge clk_i);
      drive_inputs(!released, 1'b0);
      @(negedge clk_i);
      check_cycle(c);
      if (calc_en_o) begin
        dut_count[int'(step_o)]++;
      end
      if (!released && (credit_m >= fifo_depth)) begin
        stall_cycles++;
        if (stall_cycles >= 8) begin
          released = 1'b1;  // give output handshakes again
        end
      end
      cycles++;
    end
    if (step_m != ita_step_pkg::Idle) begin
      errors++;
      $display("case %0d: timeout, the step did not return to idle", idx);
    end
    @(posedge clk_i);
    drive_inputs(1'b0, 1'b1);
    @(negedge clk_i);
    check_cycle(c);  // last padded beat, back in idle
    if (c.layer == ita_step_pkg::Linear) begin
      check_value("calc_en_o count in MatMul", dut_count[int'(ita_step_pkg::MatMul)],
                  int'(c.tile_s) * int'(c.tile_p) * int'(c.tile_e) * beats);
    end else begin
      check_value("calc_en_o count in F1", dut_count[int'(ita_step_pkg::F1)],
                  int'(c.tile_s) * int'(c.tile_f) * int'(c.tile_e) * beats);
      check_value("calc_en_o count in F2", dut_count[int'(ita_step_pkg::F2)],
                  int'(c.tile_s) * int'(c.tile_e) * int'(c.tile_f) * beats);
    end
    if (c.stall && !released) begin
      errors++;
      $display("case %0d: acceptances never stopped on the output credit", idx);
    end
    tests++;
    $display("test %0d %s done with %0d errors", tests,
             (c.layer == ita_step_pkg::Linear) ? "linear" : "feedforward",
             errors - errors_before);
  endtask

  initial begin
    void'($urandom(32'h7e430406));
    // layer, tile_s, tile_e, tile_f, tile_p, seq_length, embed_size, ff_size, stall
    cases[0] = '{ita_step_pkg::Linear, 8'd2, 8'd2, 8'd1, 8'd2, 16'd8, 16'd8, 16'd8, 1'b0};
    cases[1] = '{ita_step_pkg::Feedforward, 8'd2, 8'd2, 8'd2, 8'd1, 16'd7, 16'd6, 16'd5,
                 1'b0};
    cases[2] = '{ita_step_pkg::Feedforward, 8'd1, 8'd1, 8'd3, 8'd1, 16'd3, 16'd2, 16'd9,
                 1'b0};
    cases[3] = '{ita_step_pkg::Linear, 8'd1, 8'd1, 8'd1, 8'd3, 16'd4, 16'd4, 16'd4, 1'b1};
    errors   = 0;
    checks   = 0;
    tests    = 0;
    step_m   = ita_step_pkg::Idle;
    n_m      = 0;
    credit_m = 0;
    exp_bias = '0;
    exp_req  = '0;
    rst_ni   = 1'b0;
    start_i  = 1'b0;
    layer_i  = ita_step_pkg::Linear;
    tile_s_i = '0;
    tile_e_i = '0;
    tile_f_i = '0;
    tile_p_i = '0;
    seq_length_i   = '0;
    embed_size_i   = '0;
    ff_size_i      = '0;
    inp_valid_i    = 1'b1;  // valids up in reset, readies must stay low
    weight_valid_i = 1'b1;
    bias_valid_i   = 1'b1;
    oup_valid_i    = 1'b0;
    oup_ready_i    = 1'b0;
    inp_bias_i     = '1;
    requant_add_i  = 1'b1;
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    check_cycle(cases[0]);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    drive_inputs(1'b0, 1'b1);
    @(negedge clk_i);
    check_cycle(cases[0]);
    tests++;
    $display("test %0d reset done with %0d errors", tests, errors);
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/ita_cfg_pkg.sv
hw/ita_step_pkg.sv
hw/ita_beat_gate.sv
hw/ita_tile_sequencer.sv
hw/ita_edge_padder.sv
hw/ita_controller.sv
verification/ita_controller_sva.sv
verification/ita_controller_tb.sv

// ==== Makefile ====
# Verilator simulation of the tile controller testbench

VERILATOR ?= verilator
TOP       ?= ita_controller_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
